// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_fetch_stage
FILELIST := tb.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF 'TEST RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/branch_predecode.sv
module branch_predecode import fetch_pkg::*; (
	fetch_slot_if.decode slot,
	output branch_kind_t kind,
	output logic [63:0]  offset
);

	// ******************************
	// word views
	// ******************************

	rv_inst_t    word;
	logic [63:0] imm_b;
	logic [63:0] imm_j;

	assign word = slot.inst;

	// B immediate, sign taken from bit 31
	assign imm_b = {{51{word.b.imm12}}, word.b.imm12, word.b.imm11,
		word.b.imm10_5, word.b.imm4_1, 1'b0};

	// J immediate, same sign bit, other layout
	assign imm_j = {{43{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
		word.j.imm11, word.j.imm10_1, 1'b0};

	// ******************************
	// classify
	// ******************************

	always_comb begin
		kind = none;
		if (slot.hit) begin
			if (word.j.opcode == 7'b1101111) begin
				// jal
				kind = jal;
			end else if (word.b.opcode == 7'b1100011) begin
				// beq bne blt bge bltu bgeu, 010 and 011 are reserved
				case (word.b.funct3)
					3'b000, 3'b001, 3'b100,
					3'b101, 3'b110, 3'b111: kind = cond_branch;
					default:                kind = none;
				endcase
			end
		end
	end

	// offset only meaningful for a branch or jal
	always_comb begin
		case (kind)
			jal:         offset = imm_j;
			cond_branch: offset = imm_b;
			default:     offset = '0;
		endcase
	end

endmodule

// File: hdl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ******************************
// fetch stage parameters
// ******************************

// pc and address width
`define FETCH_XLEN 64

// first fetch address after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// direct mapped, 64-bit lines
// two instructions per line
`define ICACHE_LINES 16

`endif

// File: hdl/fetch_output_reg.sv
`include "fetch_config.svh"

module fetch_output_reg (
	input  logic                   clk,
	input  logic                   rst,
	fetch_slot_if.sink             slot,
	input  logic                   redirect,
	input  logic                   id_ready,
	output logic                   space,
	output logic                   id_valid,
	output logic [`FETCH_XLEN-1:0] id_pc,
	output logic [31:0]            id_inst
);

	// room for a new slot: empty, or draining this edge
	assign space = !id_valid || id_ready;

	// valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
		end else if (redirect) begin
			// flush, the held word is on the wrong path
			id_valid <= 1'b0;
		end else if (slot.advance) begin
			id_valid <= 1'b1;
		end else if (id_ready) begin
			// transfer with nothing behind it
			id_valid <= 1'b0;
		end
	end

	// pc/inst pair toward decode
	always_ff @(posedge clk) begin
		if (slot.advance) begin
			id_pc   <= slot.pc;
			id_inst <= slot.inst;
		end
	end

	// advance comes from the pc unit, so this ties the two together
	hold_a: assert property (
		@(posedge clk) disable iff (rst)
		id_valid && !id_ready |=> $stable(id_pc) && $stable(id_inst)
	) else $error("fetch_output_reg: output changed under back-pressure");

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

	// ******************************
	// instruction word views
	// ******************************

	// one 32-bit word, read as B-type or as J-type
	typedef union packed {
		// conditional branch layout
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		// jal layout
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} rv_inst_t;

	// predecode result
	typedef enum logic [1:0] {
		none        = 2'd0,
		cond_branch = 2'd1,
		jal         = 2'd2
	} branch_kind_t;

endpackage

// File: hdl/fetch_slot_if.sv
`include "fetch_config.svh"

// current fetch slot, shared by cache, predecode,
// next-pc unit and output register
interface fetch_slot_if;

	// fetch address, owned by the next-pc unit
	logic [`FETCH_XLEN-1:0] pc;
	// word at pc, valid when hit is high
	logic [31:0]            inst;
	logic                   hit;
	// slot accepted on this edge
	logic                   advance;

	// pc register side
	modport pc_side (output pc, output advance, input inst, input hit);

	// lookup side
	modport cache (input pc, output inst, output hit);

	// predecode only looks at the word
	modport decode (input inst, input hit);

	// output register side
	modport sink (input pc, input inst, input advance);

endinterface

// File: hdl/fetch_stage.sv
`include "fetch_config.svh"

module fetch_stage import fetch_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	// resolved next pc from a later stage
	input  logic                   redirect,
	input  logic [`FETCH_XLEN-1:0] redirect_pc,
	// toward decode
	output logic                   id_valid,
	output logic [`FETCH_XLEN-1:0] id_pc,
	output logic [31:0]            id_inst,
	input  logic                   id_ready,
	// line refill port
	output logic                   mem_req,
	output logic [`FETCH_XLEN-1:0] mem_addr,
	input  logic                   mem_ack,
	input  logic [63:0]            mem_data
);

	// ******************************
	// internal wiring
	// ******************************

	fetch_slot_if slot ();

	branch_kind_t kind;
	logic [63:0]  offset;
	logic         space;

	// ******************************
	// blocks
	// ******************************

	icache u_icache (
		.clk      (clk),
		.rst      (rst),
		.slot     (slot.cache),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_ack  (mem_ack),
		.mem_data (mem_data)
	);

	branch_predecode u_predecode (.slot(slot.decode), .kind(kind), .offset(offset));

	next_pc_unit u_next_pc (
		.clk(clk), .rst(rst), .slot(slot.pc_side), .kind(kind), .offset(offset),
		.space(space), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	fetch_output_reg u_out_reg (
		.clk(clk), .rst(rst), .slot(slot.sink), .redirect(redirect), .id_ready(id_ready),
		.space(space), .id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst)
	);

endmodule

// File: hdl/icache.sv
`include "fetch_config.svh"

module icache (
	input  logic                   clk,
	input  logic                   rst,
	fetch_slot_if.cache            slot,
	output logic                   mem_req,
	output logic [`FETCH_XLEN-1:0] mem_addr,
	input  logic                   mem_ack,
	input  logic [63:0]            mem_data
);

	// ******************************
	// geometry
	// ******************************

	// byte offset inside a 64-bit line
	localparam int OFF_W = 3;
	// set index
	localparam int IDX_W = $clog2(`ICACHE_LINES);
	// everything above the index
	localparam int TAG_W = `FETCH_XLEN - IDX_W - OFF_W;

	// ******************************
	// storage
	// ******************************

	logic [63:0]              line_data [`ICACHE_LINES];
	logic [TAG_W-1:0]         line_tag  [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] line_valid;

	// ******************************
	// lookup
	// ******************************

	logic [IDX_W-1:0] look_idx;
	logic [TAG_W-1:0] look_tag;
	logic [63:0]      look_line;

	assign look_idx  = slot.pc[OFF_W +: IDX_W];
	assign look_tag  = slot.pc[`FETCH_XLEN-1 -: TAG_W];
	assign look_line = line_data[look_idx];

	// combinational from pc, no pipeline stage here
	assign slot.hit = line_valid[look_idx] && (line_tag[look_idx] == look_tag);

	// pc bit 2 picks the upper or lower instruction
	assign slot.inst = slot.pc[2] ? look_line[63:32] : look_line[31:0];

	// ******************************
	// refill
	// ******************************

	logic [IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0] fill_tag;
	logic             fill_done;
	logic             start_fill;

	// fill target comes from the latched address, not from pc,
	// so a redirect during a refill does not move the write
	assign fill_idx  = mem_addr[OFF_W +: IDX_W];
	assign fill_tag  = mem_addr[`FETCH_XLEN-1 -: TAG_W];
	assign fill_done = mem_req && mem_ack;

	// one refill at a time
	assign start_fill = !mem_req && !slot.hit;

	// request state and valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_req    <= 1'b0;
			line_valid <= '0;
		end else if (fill_done) begin
			mem_req              <= 1'b0;
			line_valid[fill_idx] <= 1'b1;
		end else if (start_fill) begin
			mem_req <= 1'b1;
		end
	end

	// line data, tags and the request address
	always_ff @(posedge clk) begin
		if (fill_done) begin
			line_data[fill_idx] <= mem_data;
			line_tag[fill_idx]  <= fill_tag;
		end
		// address latched with the rising request, line aligned
		if (start_fill) begin
			mem_addr <= {slot.pc[`FETCH_XLEN-1:OFF_W], {OFF_W{1'b0}}};
		end
	end

	// ******************************
	// checks
	// ******************************

	// memory side only acknowledges a pending refill
	ack_pending_a: assert property (
		@(posedge clk) disable iff (rst)
		mem_ack |-> mem_req
	) else $error("icache: mem_ack without a pending refill");

endmodule

// File: hdl/next_pc_unit.sv
`include "fetch_config.svh"

module next_pc_unit import fetch_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	fetch_slot_if.pc_side          slot,
	input  branch_kind_t           kind,
	input  logic [63:0]            offset,
	input  logic                   space,
	input  logic                   redirect,
	input  logic [`FETCH_XLEN-1:0] redirect_pc
);

	// ******************************
	// static prediction
	// ******************************

	logic                   taken;
	logic [`FETCH_XLEN-1:0] target;
	logic [`FETCH_XLEN-1:0] seq_pc;
	logic [`FETCH_XLEN-1:0] pc_next;

	// jal always, branches only backward
	assign taken = (kind == jal) ||
		((kind == cond_branch) && offset[63]);

	assign target = slot.pc + offset;
	assign seq_pc = slot.pc + `FETCH_XLEN'd4;

	// slot moves on hit with room downstream, never on a redirect
	assign slot.advance = slot.hit && space && !redirect;

	// ******************************
	// pc select
	// ******************************

	always_comb begin
		if (redirect) begin
			// resolved pc from a later stage wins
			pc_next = redirect_pc;
		end else if (slot.advance) begin
			pc_next = taken ? target : seq_pc;
		end else begin
			// miss or stall, keep looking at the same pc
			pc_next = slot.pc;
		end
	end

	// pc register
	always_ff @(posedge clk) begin
		if (rst) begin
			slot.pc <= `FETCH_RESET_PC;
		end else begin
			slot.pc <= pc_next;
		end
	end

	// ******************************
	// checks
	// ******************************

	// holds only if redirect targets are aligned too
	pc_aligned_a: assert property (
		@(posedge clk) disable iff (rst)
		slot.pc[1:0] == 2'b00
	) else $error("next_pc_unit: pc %h not 4-byte aligned", slot.pc);

endmodule

// File: tb.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_slot_if.sv
hdl/icache.sv
hdl/branch_predecode.sv
hdl/next_pc_unit.sv
hdl/fetch_output_reg.sv
hdl/fetch_stage.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_fetch_stage.sv

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset held for a fixed number of rising edges,
	// released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: verification/tb_fetch_stage.sv
`include "fetch_config.svh"

module tb_fetch_stage;

	localparam int TRANSFERS   = 3000;
	localparam int IDLE_LIMIT  = 200;
	localparam int CYCLE_LIMIT = 100000;
	localparam int RESET_LIMIT = 20;

	logic                   clk;
	logic                   rst;
	logic                   redirect;
	logic [`FETCH_XLEN-1:0] redirect_pc;
	logic                   id_valid;
	logic [`FETCH_XLEN-1:0] id_pc;
	logic [31:0]            id_inst;
	logic                   id_ready;
	logic                   mem_req;
	logic [`FETCH_XLEN-1:0] mem_addr;
	logic                   mem_ack;
	logic [63:0]            mem_data;

	// reference model and checker state
	logic [31:0] lfsr_state    = 32'he039;
	logic [63:0] expect_pc     = `FETCH_RESET_PC;
	int          transfers     = 0;
	logic        rst_prev      = 1'b0;
	logic        redirect_prev = 1'b0;
	logic        hold_armed    = 1'b0;
	logic [63:0] held_pc       = '0;
	logic [31:0] held_inst     = '0;
	logic        req_pending   = 1'b0;
	logic [63:0] req_addr      = '0;

	tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst(rst));

	tb_mem_model u_mem (
		.clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr),
		.mem_ack(mem_ack), .mem_data(mem_data)
	);

	fetch_stage UUT (
		.clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc),
		.id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst), .id_ready(id_ready),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_data(mem_data)
	);

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return bits;
	endfunction

	// static rule: jal taken, backward branch taken, else pc + 4
	function automatic logic [63:0] predict_next_pc(input logic [63:0] pc, input logic [31:0] inst);
		logic [63:0] imm_j;
		logic [63:0] imm_b;
		logic [63:0] next;
		imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		next = pc + 64'd4;
		if (inst[6:0] == 7'b1101111) begin
			next = pc + imm_j;
		end else if (inst[6:0] == 7'b1100011 && inst[14:13] != 2'b01 && inst[31]) begin
			next = pc + imm_b;
		end
		return next;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	// ******************************
	// checks on the rising edge
	// ******************************

	always @(posedge clk) begin
		logic [31:0] image_inst;
		if (rst) begin
			expect_pc = `FETCH_RESET_PC;
			transfers = 0;
		end else begin
			if (rst_prev) begin
				assert (!id_valid) else report_error("id_valid high right after reset");
				assert (!mem_req) else report_error("mem_req high right after reset");
			end
			// flush seen one cycle after the pulse
			if (redirect_prev) begin
				assert (!id_valid) else report_error("id_valid still high after a redirect");
			end
			if (hold_armed) begin
				assert (id_pc == held_pc) else report_error($sformatf(
					"MISMATCH id_pc held: got %h expected %h", id_pc, held_pc));
				assert (id_inst == held_inst) else report_error($sformatf(
					"MISMATCH id_inst held: got %h expected %h", id_inst, held_inst));
			end
			if (mem_req) begin
				assert (mem_addr[2:0] == 3'b000) else report_error($sformatf(
					"MISMATCH mem_addr[2:0]: got %h expected %h", mem_addr[2:0], 3'b000));
			end
			// request stays up with one address until acked
			if (req_pending) begin
				assert (mem_req) else report_error("mem_req dropped before mem_ack");
				assert (mem_addr == req_addr) else report_error($sformatf(
					"MISMATCH mem_addr: got %h expected %h", mem_addr, req_addr));
			end
			if (id_valid && id_ready) begin
				if (transfers == 0) begin
					assert (id_pc == `FETCH_RESET_PC) else report_error($sformatf(
						"MISMATCH first id_pc: got %h expected %h", id_pc, `FETCH_RESET_PC));
				end
				image_inst = u_mem.image_word(id_pc);
				assert (id_pc == expect_pc) else report_error($sformatf(
					"MISMATCH id_pc: got %h expected %h", id_pc, expect_pc));
				assert (id_inst == image_inst) else report_error($sformatf(
					"MISMATCH id_inst: got %h expected %h", id_inst, image_inst));
				expect_pc = predict_next_pc(id_pc, id_inst);
				transfers++;
			end
			// redirect overrides the prediction
			if (redirect) begin
				expect_pc = redirect_pc;
			end
		end
		rst_prev      = rst;
		redirect_prev = redirect && !rst;
		hold_armed    = id_valid && !id_ready && !rst;
		held_pc       = id_pc;
		held_inst     = id_inst;
		req_pending   = mem_req && !mem_ack && !rst;
		req_addr      = mem_addr;
	end

	// ******************************
	// stimulus on the falling edge
	// ******************************

	initial begin
		int          cycles;
		int          idle;
		int          last_transfers;
		logic [31:0] draw;
		redirect    = 1'b0;
		redirect_pc = `FETCH_RESET_PC;
		id_ready    = 1'b0;
		cycles      = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > RESET_LIMIT) begin
				report_error("reset was never released");
			end
		end while (rst);
		cycles         = 0;
		idle           = 0;
		last_transfers = 0;
		while (transfers < TRANSFERS) begin
			@(negedge clk);
			cycles++;
			if (transfers != last_transfers) begin
				idle           = 0;
				last_transfers = transfers;
			end else begin
				idle++;
			end
			if (idle > IDLE_LIMIT) begin
				report_error($sformatf("no transfer to decode for %0d cycles", IDLE_LIMIT));
			end
			if (cycles > CYCLE_LIMIT) begin
				report_error("transfer count not reached within the cycle limit");
			end
			// decode ready three times in four
			draw     = lfsr_bits(2);
			id_ready = (draw[1:0] != 2'b00);
			redirect = 1'b0;
			// rare redirect, only once the first fetch has gone out
			draw = lfsr_bits(5);
			if (transfers > 0 && draw[4:0] == 5'd0) begin
				draw        = lfsr_bits(8);
				redirect    = 1'b1;
				redirect_pc = `FETCH_RESET_PC + {54'd0, draw[7:0], 2'b00};
			end
		end
		@(negedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: verification/tb_mem_model.sv
`include "fetch_config.svh"

module tb_mem_model (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mem_req,
	input  logic [`FETCH_XLEN-1:0] mem_addr,
	output logic                   mem_ack,
	output logic [63:0]            mem_data
);

	// 1 KB program image
	localparam int WORDS = 256;

	logic [31:0] image [WORDS];
	logic [31:0] lfsr_state = 32'he039;
	logic        ack_q      = 1'b0;
	logic [63:0] data_q     = '0;
	logic        busy       = 1'b0;
	logic [1:0]  wait_left  = 2'd0;

	assign mem_ack  = ack_q;
	assign mem_data = data_q;

	// ******************************
	// random source
	// ******************************

	// galois lfsr, one step per bit
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return bits;
	endfunction

	// ******************************
	// instruction encoders
	// ******************************

	function automatic logic [31:0] encode_jal(input int off, input logic [4:0] rd);
		logic [31:0] o;
		o = off;
		return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
	endfunction

	// regs packs rs2 then rs1
	function automatic logic [31:0] encode_branch(input int off, input logic [2:0] f3,
		input logic [9:0] regs);
		logic [31:0] o;
		o = off;
		return {o[12], o[10:5], regs[9:5], regs[4:0], f3, o[4:1], o[11], 7'b1100011};
	endfunction

	// word lookup, also used by the checker
	// outside the image a pattern built from the full address
	function automatic logic [31:0] image_word(input logic [63:0] addr);
		logic [63:0] rel;
		rel = addr - `FETCH_RESET_PC;
		if (rel < 64'(WORDS * 4)) begin
			return image[rel[9:2]];
		end
		return addr[63:32] ^ addr[31:0] ^ 32'h5a5a_0013;
	endfunction

	// ******************************
	// image fill
	// ******************************

	initial begin
		int          k;
		logic [31:0] draw;
		for (int i = 0; i < WORDS; i++) begin
			draw = lfsr_bits(4);
			// small offset in words, never zero
			k = int'(draw[3:0]) - 8;
			if (k == 0) begin
				k = 1;
			end
			// keep every target inside the image
			if (i + k < 0 || i + k >= WORDS) begin
				k = -k;
			end
			draw = lfsr_bits(2);
			if (i == WORDS - 1) begin
				// last word jumps back to the start
				image[i] = encode_jal(-4 * (WORDS - 1), 5'd1);
			end else if (draw[1:0] == 2'd0) begin
				draw = lfsr_bits(5);
				image[i] = encode_jal(4 * k, draw[4:0]);
			end else if (draw[1:0] == 2'd1) begin
				draw = lfsr_bits(13);
				// 010 and 011 are not branches, move them to 110 and 111
				if (draw[2:1] == 2'b01) begin
					draw[2] = 1'b1;
				end
				image[i] = encode_branch(4 * k, draw[2:0], draw[12:3]);
			end else begin
				// op-imm word, never a control transfer
				draw = lfsr_bits(25);
				image[i] = {draw[24:0], 7'b0010011};
			end
		end
	end

	// ******************************
	// refill responder
	// ******************************

	// outputs move on the falling edge
	// ack after 1 to 4 cycles, one cycle wide
	always @(negedge clk) begin
		logic [31:0] draw;
		if (rst) begin
			ack_q <= 1'b0;
			busy = 1'b0;
		end else if (ack_q) begin
			ack_q <= 1'b0;
		end else if (mem_req) begin
			if (!busy) begin
				busy = 1'b1;
				draw = lfsr_bits(2);
				wait_left = draw[1:0];
			end
			if (wait_left == 2'd0) begin
				ack_q  <= 1'b1;
				data_q <= {image_word(mem_addr + 64'd4), image_word(mem_addr)};
				busy = 1'b0;
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end
	end

endmodule
